// File: logic/csr_pkg.sv
package csr_pkg;

    localparam int XLEN      = 32;
    localparam int CNT_WIDTH = 64;

    //////////////////////////////
    // Types
    //////////////////////////////

    typedef enum logic [11:0] {
        CSR_MSTATUS    = 12'h300,
        CSR_MISA       = 12'h301,
        CSR_MIE        = 12'h304,
        CSR_MTVEC      = 12'h305,
        CSR_MSCRATCH   = 12'h340,
        CSR_MEPC       = 12'h341,
        CSR_MCAUSE     = 12'h342,
        CSR_MTVAL      = 12'h343,
        CSR_MIP        = 12'h344,
        CSR_MCYCLE     = 12'hB00,
        CSR_MINSTRET   = 12'hB02,
        CSR_MCYCLEH    = 12'hB80,
        CSR_MINSTRETH  = 12'hB82,
        CSR_CYCLE      = 12'hC00,
        CSR_INSTRET    = 12'hC02,
        CSR_CYCLEH     = 12'hC80,
        CSR_INSTRETH   = 12'hC82,
        CSR_MVENDORID  = 12'hF11,
        CSR_MARCHID    = 12'hF12,
        CSR_MIMPID     = 12'hF13,
        CSR_MHARTID    = 12'hF14,
        CSR_MCONFIGPTR = 12'hF15
    } csr_addr_e;

    typedef enum logic [1:0] {
        CSR_WRITE = 2'b01,
        CSR_SET   = 2'b10,
        CSR_CLEAR = 2'b11
    } csr_op_e;

    // Register hit by a decoded software write
    typedef enum logic [3:0] {
        TGT_NONE, TGT_MSTATUS, TGT_MISA, TGT_MIE, TGT_MTVEC, TGT_MSCRATCH, TGT_MEPC,
        TGT_MCAUSE, TGT_MTVAL, TGT_MCYCLE, TGT_MCYCLEH, TGT_MINSTRET, TGT_MINSTRETH
    } csr_target_e;

    typedef enum logic [4:0] {
        ILLEGAL_INSTRUCTION = 5'd2,
        BREAKPOINT          = 5'd3,
        ECALL_FROM_MMODE    = 5'd11
    } exc_code_e;

    typedef enum logic [4:0] {
        M_SW_INT  = 5'd3,
        M_TIM_INT = 5'd7,
        M_EXT_INT = 5'd11
    } irq_code_e;

    typedef enum logic [1:0] {
        PRIV_USER    = 2'b00,
        PRIV_MACHINE = 2'b11
    } priv_e;

    //////////////////////////////
    // Masks and reset values
    //////////////////////////////

    localparam logic [XLEN-1:0] MSTATUS_WMASK = 32'h007E19AA;
    localparam logic [XLEN-1:0] MISA_WMASK    = 32'h3C000000;
    localparam logic [XLEN-1:0] MIE_WMASK     = 32'h00000888; // MSIE, MTIE, MEIE
    localparam logic [XLEN-1:0] MTVEC_WMASK   = 32'hFFFFFFFC;
    localparam logic [XLEN-1:0] MEPC_WMASK    = 32'hFFFFFFFC;
    localparam logic [XLEN-1:0] DEFAULT_WMASK = 32'hFFFFFFFF;

    localparam logic [XLEN-1:0] MISA_RESET = 32'h40000100; // RV32I

    // mstatus fields
    localparam int MIE_BIT  = 3;
    localparam int MPIE_BIT = 7;
    localparam int MPP_LSB  = 11;

endpackage

// File: logic/csr_access.sv
module csr_access
    import csr_pkg::*;
#(
    parameter logic [XLEN-1:0] HART_ID = '0
) (
    input  logic                 read_enable_i,
    input  logic                 write_enable_i,
    input  logic                 killed_i,
    input  logic                 trap_taken_i,
    input  csr_op_e              operation_i,
    input  logic [11:0]          address_i,
    input  logic [XLEN-1:0]      data_i,

    input  logic [XLEN-1:0]      mstatus_i,
    input  logic [XLEN-1:0]      misa_i,
    input  logic [XLEN-1:0]      mie_i,
    input  logic [XLEN-1:0]      mtvec_i,
    input  logic [XLEN-1:0]      mscratch_i,
    input  logic [XLEN-1:0]      mepc_i,
    input  logic [XLEN-1:0]      mcause_i,
    input  logic [XLEN-1:0]      mtval_i,
    input  logic [XLEN-1:0]      mip_i,
    input  logic [CNT_WIDTH-1:0] mcycle_i,
    input  logic [CNT_WIDTH-1:0] minstret_i,

    output csr_target_e          wr_target_o,
    output logic [XLEN-1:0]      wr_data_o,
    output logic [XLEN-1:0]      data_o
);

    csr_addr_e   csr;
    csr_target_e target;
    logic [XLEN-1:0] current_val;
    logic [XLEN-1:0] wmask;
    logic read_allowed;
    logic write_allowed;

    assign csr           = csr_addr_e'(address_i);
    assign read_allowed  = read_enable_i & ~killed_i;
    assign write_allowed = write_enable_i & ~killed_i;

    //////////////////////////////
    // Write decode
    //////////////////////////////

    always_comb begin
        current_val = '0;
        wmask       = '0;
        target      = TGT_NONE; // Read-only and unknown addresses
        case (csr)
            CSR_MSTATUS:   begin current_val = mstatus_i;  wmask = MSTATUS_WMASK; target = TGT_MSTATUS; end
            CSR_MISA:      begin current_val = misa_i;     wmask = MISA_WMASK;    target = TGT_MISA; end
            CSR_MIE:       begin current_val = mie_i;      wmask = MIE_WMASK;     target = TGT_MIE; end
            CSR_MTVEC:     begin current_val = mtvec_i;    wmask = MTVEC_WMASK;   target = TGT_MTVEC; end
            CSR_MSCRATCH:  begin current_val = mscratch_i; wmask = DEFAULT_WMASK; target = TGT_MSCRATCH; end
            CSR_MEPC:      begin current_val = mepc_i;     wmask = MEPC_WMASK;    target = TGT_MEPC; end
            CSR_MCAUSE:    begin current_val = mcause_i;   wmask = DEFAULT_WMASK; target = TGT_MCAUSE; end
            CSR_MTVAL:     begin current_val = mtval_i;    wmask = DEFAULT_WMASK; target = TGT_MTVAL; end
            CSR_MCYCLE:    begin current_val = mcycle_i[31:0];    wmask = DEFAULT_WMASK; target = TGT_MCYCLE; end
            CSR_MCYCLEH:   begin current_val = mcycle_i[63:32];   wmask = DEFAULT_WMASK; target = TGT_MCYCLEH; end
            CSR_MINSTRET:  begin current_val = minstret_i[31:0];  wmask = DEFAULT_WMASK; target = TGT_MINSTRET; end
            CSR_MINSTRETH: begin current_val = minstret_i[63:32]; wmask = DEFAULT_WMASK; target = TGT_MINSTRETH; end
            default: ;
        endcase
    end

    always_comb begin
        case (operation_i)
            CSR_SET:   wr_data_o = (current_val | data_i) & wmask;
            CSR_CLEAR: wr_data_o = (current_val & ~data_i) & wmask;
            default:   wr_data_o = data_i & wmask; // Plain write
        endcase
    end

    // Trap unit owns the registers in a trap cycle
    assign wr_target_o = (write_allowed && !trap_taken_i) ? target : TGT_NONE;

    //////////////////////////////
    // Read mux
    //////////////////////////////

    always_comb begin
        data_o = '0;
        if (read_allowed) begin
            case (csr)
                CSR_MSTATUS:   data_o = mstatus_i;
                CSR_MISA:      data_o = misa_i;
                CSR_MIE:       data_o = mie_i;
                CSR_MTVEC:     data_o = mtvec_i;
                CSR_MSCRATCH:  data_o = mscratch_i;
                CSR_MEPC:      data_o = mepc_i;
                CSR_MCAUSE:    data_o = mcause_i;
                CSR_MTVAL:     data_o = mtval_i;
                CSR_MIP:       data_o = mip_i;
                CSR_MCYCLE,
                CSR_CYCLE:     data_o = mcycle_i[31:0];
                CSR_MCYCLEH,
                CSR_CYCLEH:    data_o = mcycle_i[63:32];
                CSR_MINSTRET,
                CSR_INSTRET:   data_o = minstret_i[31:0];
                CSR_MINSTRETH,
                CSR_INSTRETH:  data_o = minstret_i[63:32];
                CSR_MHARTID:   data_o = HART_ID;
                default:       data_o = '0; // Other ID registers read zero
            endcase
        end
    end

endmodule

// File: logic/trap_regs.sv
module trap_regs
    import csr_pkg::*;
(
    input  logic            clk,
    input  logic            reset,

    input  logic            raise_exception_i,
    input  logic            machine_return_i,
    input  logic            interrupt_ack_i,
    input  exc_code_e       exception_code_i,
    input  irq_code_e       irq_code_i,
    input  logic [XLEN-1:0] pc_i,
    input  logic [XLEN-1:0] instruction_i,

    input  csr_target_e     wr_target_i,
    input  logic [XLEN-1:0] wr_data_i,

    output logic            trap_taken_o,
    output priv_e           privilege_o,
    output logic [XLEN-1:0] mstatus_o,
    output logic [XLEN-1:0] misa_o,
    output logic [XLEN-1:0] mie_o,
    output logic [XLEN-1:0] mtvec_o,
    output logic [XLEN-1:0] mscratch_o,
    output logic [XLEN-1:0] mepc_o,
    output logic [XLEN-1:0] mcause_o,
    output logic [XLEN-1:0] mtval_o
);

    logic [XLEN-1:0] mstatus;
    logic [XLEN-1:0] misa;
    logic [XLEN-1:0] mie;
    logic [XLEN-1:0] mtvec;
    logic [XLEN-1:0] mscratch;
    logic [XLEN-1:0] mepc;
    logic [XLEN-1:0] mcause;
    logic [XLEN-1:0] mtval;
    priv_e           privilege;
    logic            mpp_is_machine;
    logic            exc_at_pc;

    assign trap_taken_o   = machine_return_i | raise_exception_i | interrupt_ack_i;
    assign mpp_is_machine = (mstatus[MPP_LSB +: 2] == PRIV_MACHINE);

    // ECALL and EBREAK return to the trapping instruction itself
    assign exc_at_pc = (exception_code_i == ECALL_FROM_MMODE) ||
                       (exception_code_i == BREAKPOINT);

    always_ff @(posedge clk) begin
        if (reset) begin
            mstatus   <= '0;
            misa      <= MISA_RESET;
            mie       <= '0;
            mtvec     <= '0;
            mscratch  <= '0;
            mepc      <= '0;
            mcause    <= '0;
            mtval     <= '0;
            privilege <= PRIV_MACHINE;
        end else if (machine_return_i) begin
            mstatus[MIE_BIT] <= mstatus[MPIE_BIT];
            privilege        <= mpp_is_machine ? PRIV_MACHINE : PRIV_USER; // M and U only
        end else if (raise_exception_i) begin
            mcause                 <= {1'b0, {(XLEN-6){1'b0}}, exception_code_i};
            mstatus[MPP_LSB +: 2]  <= privilege;
            mstatus[MPIE_BIT]      <= mstatus[MIE_BIT];
            mstatus[MIE_BIT]       <= 1'b0;
            privilege              <= PRIV_MACHINE;
            mepc                   <= exc_at_pc ? pc_i : pc_i + XLEN'(4);
            mtval                  <= (exception_code_i == ILLEGAL_INSTRUCTION) ? instruction_i
                                                                                : pc_i;
        end else if (interrupt_ack_i) begin
            mcause                 <= {1'b1, {(XLEN-6){1'b0}}, irq_code_i};
            mstatus[MPP_LSB +: 2]  <= privilege;
            mstatus[MPIE_BIT]      <= mstatus[MIE_BIT];
            mstatus[MIE_BIT]       <= 1'b0;
            privilege              <= PRIV_MACHINE;
            mepc                   <= pc_i; // Interrupted instruction restarts
        end else begin
            case (wr_target_i)
                TGT_MSTATUS:  mstatus  <= wr_data_i;
                TGT_MISA:     misa     <= wr_data_i;
                TGT_MIE:      mie      <= wr_data_i;
                TGT_MTVEC:    mtvec    <= wr_data_i;
                TGT_MSCRATCH: mscratch <= wr_data_i;
                TGT_MEPC:     mepc     <= wr_data_i;
                TGT_MCAUSE:   mcause   <= wr_data_i;
                TGT_MTVAL:    mtval    <= wr_data_i;
                default: ;    // Counter halves live elsewhere
            endcase
        end
    end

    assign privilege_o = privilege;
    assign mstatus_o   = mstatus;
    assign misa_o      = misa;
    assign mie_o       = mie;
    assign mtvec_o     = mtvec;
    assign mscratch_o  = mscratch;
    assign mepc_o      = mepc;
    assign mcause_o    = mcause;
    assign mtval_o     = mtval;

endmodule

// File: logic/machine_counters.sv
module machine_counters
    import csr_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 killed_i,
    input  csr_target_e          wr_target_i,
    input  logic [XLEN-1:0]      wr_data_i,

    output logic [CNT_WIDTH-1:0] mcycle_o,
    output logic [CNT_WIDTH-1:0] minstret_o
);

    // Software write to one half wins over the increment
    function automatic logic [CNT_WIDTH-1:0] next_count(
        input logic [CNT_WIDTH-1:0] count,
        input logic                 inc,
        input logic                 wr_lo,
        input logic                 wr_hi,
        input logic [XLEN-1:0]      data
    );
        logic [CNT_WIDTH-1:0] result;
        result = inc ? count + CNT_WIDTH'(1) : count;
        if (wr_lo) begin
            result = {count[CNT_WIDTH-1:XLEN], data};
        end else if (wr_hi) begin
            result = {data, count[XLEN-1:0]};
        end
        return result;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            mcycle_o   <= '0;
            minstret_o <= '0;
        end else begin
            mcycle_o   <= next_count(mcycle_o, 1'b1, wr_target_i == TGT_MCYCLE,
                                     wr_target_i == TGT_MCYCLEH, wr_data_i);
            minstret_o <= next_count(minstret_o, ~killed_i, wr_target_i == TGT_MINSTRET,
                                     wr_target_i == TGT_MINSTRETH, wr_data_i); // Retired only
        end
    end

endmodule

// File: logic/irq_ctrl.sv
module irq_ctrl
    import csr_pkg::*;
(
    input  logic            clk,
    input  logic            reset,
    input  logic            mstatus_mie_i,
    input  logic [XLEN-1:0] mie_i,
    input  logic [XLEN-1:0] irq_i,
    input  logic            interrupt_ack_i,

    output logic [XLEN-1:0] mip_o,
    output logic            interrupt_pending_o,
    output irq_code_e       irq_code_o
);

    logic [XLEN-1:0] active;
    irq_code_e       next_code;

    assign active = mie_i & mip_o; // Enabled and pending lines

    // External first, then software, then timer
    always_comb begin
        if (active[M_EXT_INT]) begin
            next_code = M_EXT_INT;
        end else if (active[M_SW_INT]) begin
            next_code = M_SW_INT;
        end else begin
            next_code = M_TIM_INT;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mip_o               <= '0;
            interrupt_pending_o <= 1'b0;
        end else begin
            mip_o               <= irq_i;
            interrupt_pending_o <= mstatus_mie_i && (active != '0) && !interrupt_ack_i;
        end
    end

    always_ff @(posedge clk) begin
        if (active != '0) begin
            irq_code_o <= next_code; // Held while nothing is active
        end
    end

endmodule

// File: logic/csr_bank.sv
module csr_bank
    import csr_pkg::*;
#(
    parameter logic [XLEN-1:0] HART_ID = '0
) (
    input  logic            clk,
    input  logic            reset,

    input  logic            read_enable_i,
    input  logic            write_enable_i,
    input  logic            killed_i,
    input  csr_op_e         operation_i,
    input  logic [11:0]     address_i,
    input  logic [XLEN-1:0] data_i,
    output logic [XLEN-1:0] data_o,

    input  logic            raise_exception_i,
    input  exc_code_e       exception_code_i,
    input  logic            machine_return_i,
    input  logic [XLEN-1:0] pc_i,
    input  logic [XLEN-1:0] instruction_i,

    input  logic            interrupt_ack_i,
    input  logic [XLEN-1:0] irq_i,
    output logic            interrupt_pending_o,

    output priv_e           privilege_o,
    output logic [XLEN-1:0] mepc_o,
    output logic [XLEN-1:0] mtvec_o
);

    csr_target_e          wr_target;
    logic [XLEN-1:0]      wr_data;
    logic                 trap_taken;
    irq_code_e            irq_code;
    logic [XLEN-1:0]      mstatus, misa, mie, mscratch, mcause, mtval, mip;
    logic [CNT_WIDTH-1:0] mcycle, minstret;

    //////////////////////////////
    // Access decode and read mux
    //////////////////////////////

    csr_access #(
        .HART_ID (HART_ID)
    ) i_csr_access (
        .read_enable_i  (read_enable_i),
        .write_enable_i (write_enable_i),
        .killed_i       (killed_i),
        .trap_taken_i   (trap_taken),
        .operation_i    (operation_i),
        .address_i      (address_i),
        .data_i         (data_i),
        .mstatus_i      (mstatus),
        .misa_i         (misa),
        .mie_i          (mie),
        .mtvec_i        (mtvec_o),
        .mscratch_i     (mscratch),
        .mepc_i         (mepc_o),
        .mcause_i       (mcause),
        .mtval_i        (mtval),
        .mip_i          (mip),
        .mcycle_i       (mcycle),
        .minstret_i     (minstret),
        .wr_target_o    (wr_target),
        .wr_data_o      (wr_data),
        .data_o         (data_o)
    );

    //////////////////////////////
    // Storage blocks
    //////////////////////////////

    trap_regs i_trap_regs (
        .clk               (clk),
        .reset             (reset),
        .raise_exception_i (raise_exception_i),
        .machine_return_i  (machine_return_i),
        .interrupt_ack_i   (interrupt_ack_i),
        .exception_code_i  (exception_code_i),
        .irq_code_i        (irq_code),
        .pc_i              (pc_i),
        .instruction_i     (instruction_i),
        .wr_target_i       (wr_target),
        .wr_data_i         (wr_data),
        .trap_taken_o      (trap_taken),
        .privilege_o       (privilege_o),
        .mstatus_o         (mstatus),
        .misa_o            (misa),
        .mie_o             (mie),
        .mtvec_o           (mtvec_o),
        .mscratch_o        (mscratch),
        .mepc_o            (mepc_o),
        .mcause_o          (mcause),
        .mtval_o           (mtval)
    );

    machine_counters i_machine_counters (
        .clk         (clk),
        .reset       (reset),
        .killed_i    (killed_i),
        .wr_target_i (wr_target),
        .wr_data_i   (wr_data),
        .mcycle_o    (mcycle),
        .minstret_o  (minstret)
    );

    irq_ctrl i_irq_ctrl (
        .clk                 (clk),
        .reset               (reset),
        .mstatus_mie_i       (mstatus[MIE_BIT]), // Global enable
        .mie_i               (mie),
        .irq_i               (irq_i),
        .interrupt_ack_i     (interrupt_ack_i),
        .mip_o               (mip),
        .interrupt_pending_o (interrupt_pending_o),
        .irq_code_o          (irq_code)
    );

endmodule

// File: tests/csr_bank_tasks.svh
`ifndef CSR_BANK_TASKS_SVH
`define CSR_BANK_TASKS_SVH

//////////////////////////////
// Helpers
//////////////////////////////

// Next rising edge plus the drive delay
task automatic next_slot();
    @(posedge clk);
    #DRIVE_DELAY;
endtask

function automatic logic [31:0] rand_word();
    return $random(seed);
endfunction

task automatic begin_test(input string name);
    current_test         = name;
    test_errors_at_start = error_count;
endtask

task automatic end_test();
    if (error_count == test_errors_at_start) begin
        passed_tests++;
        $display("%s: ok", current_test);
    end else begin
        failed_tests++;
        $display("%s: %0d mismatches", current_test, error_count - test_errors_at_start);
    end
endtask

task automatic report_mismatch(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
    $display("Error in %s: %s expected %h, actual %h", current_test, what, expected, actual);
    error_count++;
endtask

// Write takes effect at the edge inside the task
task automatic write_csr(input csr_op_e op, input csr_addr_e addr, input logic [31:0] value,
                         input logic kill);
    write_enable = 1'b1;
    operation    = op;
    address      = addr;
    data_in      = value;
    killed       = kill;
    next_slot();
    write_enable = 1'b0;
    killed       = 1'b0;
endtask

task automatic read_csr(input csr_addr_e addr, output logic [31:0] value);
    read_enable = 1'b1;
    address     = addr;
    #1;
    value = data_out; // Combinational read settles well before the edge
    next_slot();
    read_enable = 1'b0;
endtask

task automatic expect_csr(input csr_addr_e addr, input string what,
                          input logic [31:0] expected);
    logic [31:0] value;
    read_csr(addr, value);
    if (value !== expected) report_mismatch(what, expected, value);
endtask

task automatic take_exception(input exc_code_e code, input logic [31:0] trap_pc,
                              input logic [31:0] instr, input logic [31:0] wdata);
    raise_exception = 1'b1;
    exception_code  = code;
    pc_in           = trap_pc;
    instruction     = instr;
    write_enable    = 1'b1; // Colliding software write to mscratch
    operation       = CSR_WRITE;
    address         = CSR_MSCRATCH;
    data_in         = wdata;
    next_slot();
    raise_exception = 1'b0;
    write_enable    = 1'b0;
endtask

task automatic pulse_return();
    machine_return = 1'b1;
    next_slot();
    machine_return = 1'b0;
endtask

//////////////////////////////
// Directed tests
//////////////////////////////

task automatic read_reset_values();
    begin_test("reset_values");
    expect_csr(CSR_MISA, "misa", 32'h4000_0100);
    expect_csr(CSR_MSTATUS, "mstatus", 32'h0000_0000);
    expect_csr(CSR_MHARTID, "mhartid", HART_ID);
    if (privilege !== PRIV_MACHINE) report_mismatch("privilege", 32'd3, 32'(privilege));
    end_test();
endtask

// Write, set, clear and a killed write on one register
task automatic access_one_reg(input string what, input csr_addr_e addr,
                              input logic [31:0] mask);
    logic [31:0] expected;
    logic [31:0] wdata;
    wdata    = rand_word();
    expected = wdata & mask;
    write_csr(CSR_WRITE, addr, wdata, 1'b0);
    expect_csr(addr, {what, " after write"}, expected);
    wdata    = rand_word();
    expected = (expected | wdata) & mask;
    write_csr(CSR_SET, addr, wdata, 1'b0);
    expect_csr(addr, {what, " after set"}, expected);
    wdata    = rand_word();
    expected = (expected & ~wdata) & mask;
    write_csr(CSR_CLEAR, addr, wdata, 1'b0);
    expect_csr(addr, {what, " after clear"}, expected);
    write_csr(CSR_WRITE, addr, ~expected, 1'b1); // Differs in every writable bit
    expect_csr(addr, {what, " after killed write"}, expected);
endtask

task automatic exercise_csr_access();
    begin_test("csr_access");
    access_one_reg("mscratch", CSR_MSCRATCH, 32'hFFFF_FFFF);
    access_one_reg("mie", CSR_MIE, MIE_WMASK);
    access_one_reg("mtvec", CSR_MTVEC, MTVEC_WMASK);
    write_csr(CSR_WRITE, CSR_MTVEC, 32'h8000_0103, 1'b0); // Low two bits stay zero
    if (mtvec_out !== 32'h8000_0100) report_mismatch("mtvec port", 32'h8000_0100, mtvec_out);
    end_test();
endtask

task automatic enter_exceptions();
    logic [31:0] scratch;
    logic [31:0] trap_pc;
    logic [31:0] instr;
    begin_test("exception_entry");
    write_csr(CSR_WRITE, CSR_MSTATUS, 32'h0000_0008, 1'b0); // MIE on, MPP user
    read_csr(CSR_MSCRATCH, scratch);
    trap_pc = rand_word() & 32'hFFFF_FFFC;
    instr   = rand_word();
    take_exception(ECALL_FROM_MMODE, trap_pc, instr, ~scratch);
    expect_csr(CSR_MCAUSE, "ecall mcause", 32'h0000_000B);
    expect_csr(CSR_MEPC, "ecall mepc", trap_pc);
    if (mepc_out !== trap_pc) report_mismatch("ecall mepc port", trap_pc, mepc_out);
    expect_csr(CSR_MTVAL, "ecall mtval", trap_pc);
    expect_csr(CSR_MSCRATCH, "mscratch under trap", scratch);
    expect_csr(CSR_MSTATUS, "ecall mstatus", 32'h0000_1880); // MPIE set, MPP machine

    trap_pc = rand_word() & 32'hFFFF_FFFC;
    instr   = rand_word();
    take_exception(ILLEGAL_INSTRUCTION, trap_pc, instr, ~scratch);
    expect_csr(CSR_MCAUSE, "illegal mcause", 32'h0000_0002);
    expect_csr(CSR_MEPC, "illegal mepc", trap_pc + 32'd4);
    expect_csr(CSR_MTVAL, "illegal mtval", instr);
    expect_csr(CSR_MSCRATCH, "mscratch under trap", scratch);
    expect_csr(CSR_MSTATUS, "illegal mstatus", 32'h0000_1800);
    end_test();
endtask

task automatic return_from_trap();
    begin_test("trap_return");
    write_csr(CSR_WRITE, CSR_MSTATUS, 32'h0000_0080, 1'b0); // MPIE set, MPP user
    pulse_return();
    if (privilege !== PRIV_USER) report_mismatch("privilege to user", 32'd0, 32'(privilege));
    expect_csr(CSR_MSTATUS, "mstatus after return", 32'h0000_0088);
    write_csr(CSR_WRITE, CSR_MSTATUS, 32'h0000_1880, 1'b0); // Back to machine
    pulse_return();
    if (privilege !== PRIV_MACHINE) begin
        report_mismatch("privilege to machine", 32'd3, 32'(privilege));
    end
    expect_csr(CSR_MSTATUS, "mstatus after return", 32'h0000_1888);
    end_test();
endtask

task automatic raise_interrupts();
    logic [31:0] trap_pc;
    logic [31:0] noise;
    begin_test("interrupts");
    write_csr(CSR_WRITE, CSR_MSTATUS, 32'h0000_0008, 1'b0);
    write_csr(CSR_WRITE, CSR_MIE, 32'h0000_0800, 1'b0); // External line only
    irq = 32'h0000_0800;
    next_slot(); // mip sampled here
    if (interrupt_pending !== 1'b0) begin
        report_mismatch("pending one edge", 32'd0, 32'(interrupt_pending));
    end
    next_slot();
    if (interrupt_pending !== 1'b1) begin
        report_mismatch("pending two edges", 32'd1, 32'(interrupt_pending));
    end
    trap_pc       = rand_word() & 32'hFFFF_FFFC;
    interrupt_ack = 1'b1;
    pc_in         = trap_pc;
    next_slot();
    interrupt_ack = 1'b0;
    irq           = '0;
    if (interrupt_pending !== 1'b0) begin
        report_mismatch("pending after ack", 32'd0, 32'(interrupt_pending));
    end
    expect_csr(CSR_MCAUSE, "irq mcause", 32'h8000_000B);
    expect_csr(CSR_MSTATUS, "irq mstatus", 32'h0000_1880);
    expect_csr(CSR_MEPC, "irq mepc", trap_pc);

    // Lines outside mie must stay quiet, software and timer lines included
    write_csr(CSR_WRITE, CSR_MSTATUS, 32'h0000_0008, 1'b0);
    noise = (rand_word() | 32'h0000_0088) & ~32'h0000_0800;
    irq   = noise;
    repeat (4) begin
        next_slot();
        if (interrupt_pending !== 1'b0) begin
            report_mismatch("pending from masked line", 32'd0, 32'(interrupt_pending));
        end
    end
    expect_csr(CSR_MIP, "mip", noise);
    irq = '0;
    end_test();
endtask

task automatic run_counters();
    logic [31:0] value;
    logic [31:0] start;
    logic [31:0] high;
    int          k;
    begin_test("counters");
    start = rand_word();
    k     = 1 + int'(rand_word() & 32'h7);
    write_csr(CSR_WRITE, CSR_MCYCLE, start, 1'b0);
    repeat (k) next_slot();
    expect_csr(CSR_MCYCLE, "mcycle after k cycles", start + 32'(k));

    read_csr(CSR_MINSTRET, value); // One retire follows at this edge
    killed = 1'b1;
    repeat (5) next_slot();
    killed = 1'b0;
    expect_csr(CSR_MINSTRET, "minstret while killed", value + 32'd1);

    write_csr(CSR_WRITE, CSR_MCYCLE, 32'h0000_0000, 1'b0); // No carry into the high half
    high = rand_word();
    write_csr(CSR_WRITE, CSR_MCYCLEH, high, 1'b0);
    expect_csr(CSR_MCYCLEH, "mcycleh", high);
    expect_csr(CSR_CYCLEH, "cycleh alias", high);
    end_test();
endtask

`endif

// File: tests/csr_bank_tb.sv
module csr_bank_tb
    import csr_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int          CLK_PERIOD   = 100;
    localparam int          DRIVE_DELAY  = 10;
    localparam int          RESET_CYCLES = 8;
    localparam logic [31:0] HART_ID      = 32'h0000_0003;

    // Six tests take about 110 cycles plus margin
    localparam int WATCHDOG_CYCLES = 400;

    logic        clk;
    logic        reset;
    logic        read_enable;
    logic        write_enable;
    logic        killed;
    csr_op_e     operation;
    logic [11:0] address;
    logic [31:0] data_in;
    logic [31:0] data_out;
    logic        raise_exception;
    exc_code_e   exception_code;
    logic        machine_return;
    logic [31:0] pc_in;
    logic [31:0] instruction;
    logic        interrupt_ack;
    logic [31:0] irq;
    logic        interrupt_pending;
    priv_e       privilege;
    logic [31:0] mepc_out;
    logic [31:0] mtvec_out;

    integer seed = 32'hce69f541;
    string  current_test;
    int     error_count;
    int     test_errors_at_start;
    int     passed_tests;
    int     failed_tests;

    csr_bank #(
        .HART_ID (HART_ID)
    ) i_csr_bank (
        .clk                 (clk),
        .reset               (reset),
        .read_enable_i       (read_enable),
        .write_enable_i      (write_enable),
        .killed_i            (killed),
        .operation_i         (operation),
        .address_i           (address),
        .data_i              (data_in),
        .data_o              (data_out),
        .raise_exception_i   (raise_exception),
        .exception_code_i    (exception_code),
        .machine_return_i    (machine_return),
        .pc_i                (pc_in),
        .instruction_i       (instruction),
        .interrupt_ack_i     (interrupt_ack),
        .irq_i               (irq),
        .interrupt_pending_o (interrupt_pending),
        .privilege_o         (privilege),
        .mepc_o              (mepc_out),
        .mtvec_o             (mtvec_out)
    );

    `include "csr_bank_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    //////////////////////////////
    // Watchdog
    //////////////////////////////

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, the test sequence never finished",
                 WATCHDOG_CYCLES);
        $display("Testbench failed");
        $finish;
    end

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    initial begin
        error_count     = 0;
        passed_tests    = 0;
        failed_tests    = 0;
        reset           = 1'b1;
        read_enable     = 1'b0;
        write_enable    = 1'b0;
        killed          = 1'b0;
        operation       = CSR_WRITE;
        address         = '0;
        data_in         = '0;
        raise_exception = 1'b0;
        exception_code  = ECALL_FROM_MMODE;
        machine_return  = 1'b0;
        pc_in           = '0;
        instruction     = '0;
        interrupt_ack   = 1'b0;
        irq             = '0;

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0; // Released in a drive slot

        read_reset_values();
        exercise_csr_access();
        enter_exceptions();
        return_from_trap();
        raise_interrupts();
        run_counters();

        $display("Tests passed: %0d, failed: %0d", passed_tests, failed_tests);
        if (failed_tests == 0 && error_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: tb.f
+incdir+tests
logic/csr_pkg.sv
logic/csr_access.sv
logic/trap_regs.sv
logic/machine_counters.sv
logic/irq_ctrl.sv
logic/csr_bank.sv
tests/csr_bank_tb.sv

// File: run.sh
#!/bin/sh
# Build the CSR bank testbench with Verilator, run it and scan the log

rm -rf obj_dir sim.log

verilator --binary --timing -f tb.f --top-module csr_bank_tb -o csr_bank_sim \
    && ./obj_dir/csr_bank_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "Testbench failed" sim.log && exit 1 || exit 0
